//--- verilog/bus_pkg.sv
package bus_pkg;

    ////////////////////////////////////////
    // CPU bus side
    ////////////////////////////////////////

    // Z80 style bus inputs, all strobes active low
    typedef struct packed {
        logic [15:0] address;
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;
        logic        iorq_n;
    } bus_req_t;

    // Decoded I/O port
    typedef enum logic [2:0] {
        port_none     = 3'd0,
        port_bank0    = 3'd1,   // $F0
        port_bank1    = 3'd2,   // $F1
        port_bank2    = 3'd3,   // $F2
        port_bank3    = 3'd4,   // $F3
        port_sysctrl  = 3'd5,   // $FB
        port_cassette = 3'd6,   // $FC
        port_printer  = 3'd7    // $FE
    } io_port_e;

    // Stored port bits and synchronised inputs
    typedef struct packed {
        logic dis_psgs;         // $FB bit 1
        logic dis_regs;         // $FB bit 0
        logic cassette_out;
        logic printer_out;
        logic cassette_in;
        logic printer_in;
    } port_status_t;

endpackage

//--- verilog/map_pkg.sv
package map_pkg;

    ////////////////////////////////////////
    // Bank registers
    ////////////////////////////////////////

    localparam int NUM_BANKS = 4;

    typedef struct packed {
        logic       ro;         // Blocks writes to external memory
        logic       overlay;    // Maps system RAM at $3800-$3FFF
        logic [5:0] page;
    } bank_reg_t;

    // Power-up map: ROM page 0 with overlay, RAM 33, RAM 34, cart 19
    localparam logic [NUM_BANKS-1:0][7:0] BANK_RESET = {8'h13, 8'h22, 8'h21, 8'hC0};

    ////////////////////////////////////////
    // Page classification
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        region_rom   = 3'd0,    // Pages 0-3
        region_cart  = 3'd1,    // Pages 16-19
        region_vram  = 3'd2,    // Page 20
        region_chram = 3'd3,    // Page 21
        region_ram   = 3'd4,    // Pages 32-63
        region_none  = 3'd5
    } mem_region_e;

    localparam logic [5:0] PAGE_VRAM    = 6'd20;
    localparam logic [5:0] PAGE_CHRAM   = 6'd21;

    // Address bits 13:11 of the system RAM window
    localparam logic [2:0] SYSRAM_BLOCK = 3'b111;

    // Register plus its decoded region
    typedef struct packed {
        bank_reg_t   bank;
        mem_region_e region;
    } slot_map_t;

endpackage

//--- verilog/io_decoder.sv
`timescale 1ns/1ps

module io_decoder import bus_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic         sysclk,
    input  logic         reset,
    input  bus_req_t     bus,
    input  logic [7:0]   d_in,
    input  logic         cassette_in,
    input  logic         printer_in,
    output logic         wr_strobe,
    output logic [7:0]   wr_data,
    output io_port_e     io_sel,
    output port_status_t status
);

    // Bit positions in the synchroniser word
    localparam int SYNC_RD  = 3;
    localparam int SYNC_WR  = 2;
    localparam int SYNC_CAS = 1;
    localparam int SYNC_PRN = 0;

    logic [SYNC_STAGES-1:0][3:0] sync_q;   // [0] is the newest sample
    logic                        dis_regs;
    logic                        dis_psgs;
    logic                        cassette_out;
    logic                        printer_out;

    ////////////////////////////////////////
    // Synchronisers and write strobe
    ////////////////////////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            sync_q <= {SYNC_STAGES{4'b1100}};  // Strobes idle high
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], bus.rd_n, bus.wr_n, cassette_in, printer_in};
        end
    end

    // Falling wr_n seen at the two oldest stages, ignored during a read
    assign wr_strobe = sync_q[SYNC_STAGES-1][SYNC_WR] && !sync_q[SYNC_STAGES-2][SYNC_WR] &&
                       sync_q[SYNC_STAGES-1][SYNC_RD];

    // Data is stable well before the strobe arrives
    always_ff @(posedge sysclk) begin
        if (!bus.wr_n) begin
            wr_data <= d_in;
        end
    end

    ////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////

    always_comb begin
        io_sel = port_none;
        if (!bus.iorq_n) begin
            case (bus.address[7:0])
                8'hF0:   if (!dis_regs) io_sel = port_bank0;
                8'hF1:   if (!dis_regs) io_sel = port_bank1;
                8'hF2:   if (!dis_regs) io_sel = port_bank2;
                8'hF3:   if (!dis_regs) io_sel = port_bank3;
                8'hFB:   io_sel = port_sysctrl;
                8'hFC:   io_sel = port_cassette;
                8'hFE:   io_sel = port_printer;
                default: io_sel = port_none;
            endcase
        end
    end

    // $FB, $FC and $FE
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            dis_regs     <= 1'b0;
            dis_psgs     <= 1'b0;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else if (wr_strobe) begin
            if (io_sel == port_sysctrl)  {dis_psgs, dis_regs} <= wr_data[1:0];
            if (io_sel == port_cassette) cassette_out <= wr_data[0];
            if (io_sel == port_printer)  printer_out <= wr_data[0];
        end
    end

    assign status.dis_psgs     = dis_psgs;
    assign status.dis_regs     = dis_regs;
    assign status.cassette_out = cassette_out;
    assign status.printer_out  = printer_out;
    assign status.cassette_in  = sync_q[SYNC_STAGES-1][SYNC_CAS];
    assign status.printer_in   = sync_q[SYNC_STAGES-1][SYNC_PRN];

endmodule

//--- verilog/bank_slot.sv
`timescale 1ns/1ps

module bank_slot import bus_pkg::*, map_pkg::*; #(
    parameter int SLOT_INDEX = 0
) (
    input  logic       sysclk,
    input  logic       reset,
    input  io_port_e   io_sel,
    input  logic       wr_strobe,
    input  logic [7:0] wr_data,
    output slot_map_t  slot_map
);

    // Bank ports are consecutive, starting at port_bank0
    localparam io_port_e OWN_PORT = io_port_e'(int'(port_bank0) + SLOT_INDEX);

    bank_reg_t   bank_q;
    mem_region_e region;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_q <= bank_reg_t'(BANK_RESET[SLOT_INDEX]);
        end else if (wr_strobe && io_sel == OWN_PORT) begin
            bank_q <= bank_reg_t'(wr_data);
        end
    end

    ////////////////////////////////////////
    // Page to region
    ////////////////////////////////////////

    always_comb begin
        if (bank_q.page <= 6'd3) begin
            region = region_rom;
        end else if (bank_q.page[5]) begin
            region = region_ram;                    // 32-63
        end else if (bank_q.page[5:2] == 4'b0100) begin
            region = region_cart;                   // 16-19
        end else if (bank_q.page == PAGE_VRAM) begin
            region = region_vram;
        end else if (bank_q.page == PAGE_CHRAM) begin
            region = region_chram;
        end else begin
            region = region_none;
        end
    end

    assign slot_map.bank   = bank_q;
    assign slot_map.region = region;

endmodule

//--- verilog/mem_mapper.sv
`timescale 1ns/1ps

module mem_mapper import bus_pkg::*, map_pkg::*; (
    input  bus_req_t                    bus,
    input  io_port_e                    io_sel,
    input  port_status_t                status,
    input  slot_map_t [NUM_BANKS-1:0]   slots,
    output logic                        ram_ce_n,
    output logic                        cart_ce_n,
    output logic                        ram_we_n,
    output logic [4:0]                  ba,
    output logic [7:0]                  d_out,
    output logic                        d_oe
);

    slot_map_t act;            // Slot for the current 16K window
    logic      mem_cycle;
    logic      sel_sysram;
    logic      write_ok;
    logic      sel_ram;
    logic      sel_cart;

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////

    assign act       = slots[bus.address[15:14]];
    assign mem_cycle = !bus.mreq_n;

    // Fixed system RAM window, page 32 of the external RAM
    assign sel_sysram = mem_cycle && act.bank.overlay && bus.address[13:11] == SYSRAM_BLOCK;

    // Read-only pages get no chip select on a write
    assign write_ok = bus.wr_n || !act.bank.ro;

    // ROM, VRAM and CHRAM pages are internal and select nothing outside
    assign sel_ram  = sel_sysram || (mem_cycle && write_ok && act.region == region_ram);
    assign sel_cart = mem_cycle && !sel_sysram && write_ok && act.region == region_cart;

    assign ram_ce_n  = !sel_ram;
    assign cart_ce_n = !sel_cart;
    assign ram_we_n  = !(!bus.wr_n && (sel_sysram || (sel_ram && !act.bank.ro)));
    assign ba        = sel_sysram ? 5'd0 : act.bank.page[4:0];

    ////////////////////////////////////////
    // I/O read-back
    ////////////////////////////////////////

    always_comb begin
        d_out = 8'h00;
        case (io_sel)
            port_bank0:    d_out = slots[0].bank;
            port_bank1:    d_out = slots[1].bank;
            port_bank2:    d_out = slots[2].bank;
            port_bank3:    d_out = slots[3].bank;
            port_sysctrl:  d_out = {6'b0, status.dis_psgs, status.dis_regs};
            port_cassette: d_out = {7'b0, !status.cassette_in};   // Input is inverted
            port_printer:  d_out = {7'b0, status.printer_in};
            default:       d_out = 8'h00;
        endcase
    end

    assign d_oe = !bus.iorq_n && !bus.rd_n && io_sel != port_none;

endmodule

//--- verilog/bank_top.sv
`timescale 1ns/1ps

module bank_top import bus_pkg::*, map_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic       sysclk,
    input  logic       reset,

    // CPU bus
    input  bus_req_t   bus,
    input  logic [7:0] d_in,
    output logic [7:0] d_out,
    output logic       d_oe,

    // External memory
    output logic       ram_ce_n,
    output logic       cart_ce_n,
    output logic       ram_we_n,
    output logic [4:0] ba,

    // Cassette and printer
    input  logic       cassette_in,
    input  logic       printer_in,
    output logic       cassette_out,
    output logic       printer_out
);

    logic                        wr_strobe;
    logic [7:0]                  wr_data;
    io_port_e                    io_sel;
    port_status_t                status;
    slot_map_t [NUM_BANKS-1:0]   slot_maps;

    io_decoder #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_io_decoder (
        .sysclk      (sysclk),
        .reset       (reset),
        .bus         (bus),
        .d_in        (d_in),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .io_sel      (io_sel),
        .status      (status)
    );

    ////////////////////////////////////////
    // Bank registers $F0-$F3
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_slot
        bank_slot #(
            .SLOT_INDEX (i)
        ) u_bank_slot (
            .sysclk    (sysclk),
            .reset     (reset),
            .io_sel    (io_sel),
            .wr_strobe (wr_strobe),
            .wr_data   (wr_data),
            .slot_map  (slot_maps[i])
        );
    end

    mem_mapper u_mem_mapper (
        .bus       (bus),
        .io_sel    (io_sel),
        .status    (status),
        .slots     (slot_maps),
        .ram_ce_n  (ram_ce_n),
        .cart_ce_n (cart_ce_n),
        .ram_we_n  (ram_we_n),
        .ba        (ba),
        .d_out     (d_out),
        .d_oe      (d_oe)
    );

    assign cassette_out = status.cassette_out;
    assign printer_out  = status.printer_out;

endmodule

//--- tb/bank_top_sva.sv
`timescale 1ns/1ps

module bank_top_sva import bus_pkg::*; (
    input logic     sysclk,
    input logic     reset,
    input bus_req_t bus,
    input logic     ram_ce_n,
    input logic     cart_ce_n,
    input logic     ram_we_n,
    input logic     d_oe
);

    int fail_count = 0;     // Read by the testbench at the end of the run

    ////////////////////////////////////////
    // Chip select rules
    ////////////////////////////////////////

    // One external memory at a time
    a_single_select: assert property (@(posedge sysclk) disable iff (reset)
        !(!ram_ce_n && !cart_ce_n))
        else begin
            $error("RAM and cartridge chip selects are low together");
            fail_count++;
        end

    a_we_with_ce: assert property (@(posedge sysclk) disable iff (reset)
        !ram_we_n |-> !ram_ce_n)
        else begin
            $error("RAM write enable is low without RAM chip select");
            fail_count++;
        end

    ////////////////////////////////////////
    // Data bus drive
    ////////////////////////////////////////

    a_oe_on_io_read: assert property (@(posedge sysclk) disable iff (reset)
        d_oe |-> (!bus.rd_n && !bus.iorq_n))
        else begin
            $error("Data output enabled outside an I/O read");
            fail_count++;
        end

endmodule

bind bank_top bank_top_sva u_bank_top_sva (.*);

//--- tb/tb_bank_top.sv
`timescale 1ns/1ps

module tb_bank_top
    import bus_pkg::*;
();

    localparam int REG_WRITES       = 40;
    localparam int MEM_ACCESSES     = 200;
    localparam int RELOAD_EVERY     = 25;   // Fresh bank contents every 25 accesses
    localparam int OVERLAY_ACCESSES = 8;
    localparam int PORT_ROUNDS      = 10;

    // Each bus task takes 9 sysclk periods
    localparam int NUM_BUS_CYCLES = 7 + 2 * REG_WRITES
                                  + MEM_ACCESSES + 4 * (MEM_ACCESSES / RELOAD_EVERY)
                                  + 3 * (OVERLAY_ACCESSES + 1) + 17 + 5 * PORT_ROUNDS;
    localparam int TIMEOUT_NS     = (NUM_BUS_CYCLES * 9 + 100) * 10;

    logic       sysclk;
    logic       reset;
    bus_req_t   bus;
    logic [7:0] d_in;
    logic       cassette_in;
    logic       printer_in;
    logic [7:0] d_out;
    logic       d_oe;
    logic       ram_ce_n;
    logic       cart_ce_n;
    logic       ram_we_n;
    logic [4:0] ba;
    logic       cassette_out;
    logic       printer_out;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    // Reference model
    logic [7:0] m_bank [4];
    logic       m_dis_regs;
    logic       m_dis_psgs;
    logic       m_cas_out;
    logic       m_prn_out;

    bank_top #(
        .SYNC_STAGES (3)
    ) u_bank_top (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus          (bus),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .ram_ce_n     (ram_ce_n),
        .cart_ce_n    (cart_ce_n),
        .ram_we_n     (ram_we_n),
        .ba           (ba),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    always #5 sysclk = ~sysclk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s expected %02h actual %02h", name, expected, actual);
        end
    endtask

    task automatic bus_idle();
        bus.rd_n   = 1'b1;
        bus.wr_n   = 1'b1;
        bus.mreq_n = 1'b1;
        bus.iorq_n = 1'b1;
    endtask

    // Release the bus, then 3 idle cycles
    task automatic end_cycle();
        bus_idle();
        repeat (3) @(posedge sysclk);
        #1;
    endtask

    function automatic void model_io_write(input logic [7:0] port, input logic [7:0] data);
        case (port)
            8'hF0, 8'hF1, 8'hF2, 8'hF3: if (!m_dis_regs) m_bank[port[1:0]] = data;
            8'hFB:   {m_dis_psgs, m_dis_regs} = data[1:0];
            8'hFC:   m_cas_out = data[0];
            8'hFE:   m_prn_out = data[0];
            default: ;
        endcase
    endfunction

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        bus.address = {8'(rand_bits(8)), port};   // Upper byte is don't care
        bus.iorq_n  = 1'b0;
        bus.wr_n    = 1'b0;
        d_in        = data;
        repeat (6) @(posedge sysclk);
        #1;
        end_cycle();
        model_io_write(port, data);
    endtask

    task automatic io_read(input logic [7:0] port);
        logic [7:0] exp_data;
        logic       exp_oe;
        exp_oe   = 1'b1;
        exp_data = 8'h00;
        case (port)
            8'hF0, 8'hF1, 8'hF2, 8'hF3: begin
                exp_oe   = !m_dis_regs;
                exp_data = m_bank[port[1:0]];
            end
            8'hFB:   exp_data = {6'b0, m_dis_psgs, m_dis_regs};
            8'hFC:   exp_data = {7'b0, !cassette_in};
            8'hFE:   exp_data = {7'b0, printer_in};
            default: exp_oe = 1'b0;
        endcase
        bus.address = {8'(rand_bits(8)), port};
        bus.iorq_n  = 1'b0;
        bus.rd_n    = 1'b0;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_value("d_oe", exp_oe, d_oe);
        if (exp_oe) check_value("d_out", exp_data, d_out);
        repeat (3) @(posedge sysclk);
        #1;
        end_cycle();
    endtask

    task automatic mem_access(input logic [15:0] addr, input logic is_write);
        logic [7:0] slot;
        logic       exp_ram_ce_n;
        logic       exp_cart_ce_n;
        logic       exp_we_n;
        logic [4:0] exp_ba;
        slot          = m_bank[addr[15:14]];
        exp_ram_ce_n  = 1'b1;
        exp_cart_ce_n = 1'b1;
        exp_we_n      = 1'b1;
        exp_ba        = slot[4:0];
        if (slot[6] && addr[13:11] == 3'b111) begin
            // System RAM window ignores ro
            exp_ram_ce_n = 1'b0;
            exp_we_n     = !is_write;
            exp_ba       = 5'd0;
        end else if (!(is_write && slot[7])) begin
            if (slot[5:0] >= 6'd32) begin
                exp_ram_ce_n = 1'b0;
                exp_we_n     = !is_write;
            end else if (slot[5:0] >= 6'd16 && slot[5:0] <= 6'd19) begin
                exp_cart_ce_n = 1'b0;
            end
        end
        bus.address   = addr;
        bus.mreq_n    = 1'b0;
        if (is_write) bus.wr_n = 1'b0;
        else bus.rd_n = 1'b0;
        d_in = 8'(rand_bits(8));
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_value("ram_ce_n", exp_ram_ce_n, ram_ce_n);
        check_value("cart_ce_n", exp_cart_ce_n, cart_ce_n);
        check_value("ram_we_n", exp_we_n, ram_we_n);
        check_value("ba", exp_ba, ba);
        check_value("d_oe", 1'b0, d_oe);
        repeat (3) @(posedge sysclk);
        #1;
        end_cycle();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [7:0] port;
        logic [7:0] data;
        lfsr_state  = 32'ha633;
        errors      = 0;
        checks      = 0;
        sysclk      = 1'b0;
        reset       = 1'b1;
        bus.address = 16'h0000;
        bus_idle();
        d_in        = 8'h00;
        cassette_in = 1'b1;
        printer_in  = 1'b0;
        m_bank      = '{8'hC0, 8'h21, 8'h22, 8'h13};
        m_dis_regs  = 1'b0;
        m_dis_psgs  = 1'b0;
        m_cas_out   = 1'b0;
        m_prn_out   = 1'b0;
        repeat (10) @(posedge sysclk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge sysclk);

        // Reset state and idle bus
        @(negedge sysclk);
        check_value("ram_ce_n", 1'b1, ram_ce_n);
        check_value("cart_ce_n", 1'b1, cart_ce_n);
        check_value("ram_we_n", 1'b1, ram_we_n);
        check_value("d_oe", 1'b0, d_oe);
        @(posedge sysclk);
        #1;
        for (int b = 0; b < 4; b++) io_read(8'(8'hF0 + b));
        io_read(8'hFB);
        io_read(8'hFC);
        io_read(8'hFE);

        for (int i = 0; i < REG_WRITES; i++) begin
            port = 8'(8'hF0 + rand_bits(2));
            data = 8'(rand_bits(8));
            io_write(port, data);
            io_read(port);
        end

        for (int i = 0; i < MEM_ACCESSES; i++) begin
            if (i % RELOAD_EVERY == 0) begin
                for (int b = 0; b < 4; b++) io_write(8'(8'hF0 + b), 8'(rand_bits(8)));
            end
            mem_access(16'(rand_bits(16)), 1'(rand_bits(1)));
        end

        // System RAM overlay in bank 0
        io_write(8'hF0, {2'b01, 6'(rand_bits(6))});
        for (int j = 0; j < OVERLAY_ACCESSES; j++) begin
            mem_access({5'b00111, 11'(rand_bits(11))}, 1'(rand_bits(1)));
        end
        io_write(8'hF0, {2'b11, 6'(rand_bits(6))});     // Read-only as well
        for (int j = 0; j < OVERLAY_ACCESSES; j++) begin
            mem_access({5'b00111, 11'(rand_bits(11))}, 1'b1);
        end
        io_write(8'hF0, {2'b00, 6'(rand_bits(6))});
        for (int j = 0; j < OVERLAY_ACCESSES; j++) begin
            mem_access({5'b00111, 11'(rand_bits(11))}, 1'(rand_bits(1)));
        end

        // Bank port lockout through $FB
        io_write(8'hFB, 8'h01);
        io_read(8'hFB);
        for (int b = 0; b < 4; b++) io_write(8'(8'hF0 + b), 8'(rand_bits(8)));
        for (int b = 0; b < 4; b++) io_read(8'(8'hF0 + b));
        io_write(8'hFB, 8'h02);
        io_read(8'hFB);
        for (int b = 0; b < 4; b++) io_read(8'(8'hF0 + b));
        io_write(8'hFB, 8'h00);

        for (int i = 0; i < PORT_ROUNDS; i++) begin
            io_write(8'hFC, 8'(rand_bits(8)));
            io_write(8'hFE, 8'(rand_bits(8)));
            check_value("cassette_out", m_cas_out, cassette_out);
            check_value("printer_out", m_prn_out, printer_out);
            cassette_in = 1'(rand_bits(1));
            printer_in  = 1'(rand_bits(1));
            repeat (6) @(posedge sysclk);   // Through the input synchroniser
            #1;
            io_read(8'hFC);
            io_read(8'hFE);
        end

        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_bank_top.u_bank_top_sva.fail_count);
        if (errors == 0 && u_bank_top.u_bank_top_sva.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- sources.f
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/io_decoder.sv
verilog/bank_slot.sv
verilog/mem_mapper.sv
verilog/bank_top.sv
tb/bank_top_sva.sv
tb/tb_bank_top.sv
